//--- verilog/ddcRegPkg.sv
/*
  Register map of the down-converter.
  Holds the bus widths, the register addresses and the settings struct
  that the register block hands to the DSP chain. Import it where the
  addresses or the settings fields are needed.
*/

package ddcRegPkg;

    localparam int addrWidth = 13;
    localparam int dataWidth = 32;

    localparam logic [addrWidth-1:0] ddcCenterFreqAddr = 13'd0;
    localparam logic [addrWidth-1:0] ddcControlAddr    = 13'd1;
    localparam logic [addrWidth-1:0] ddcDecimationAddr = 13'd2;

    // settings as seen by the DSP chain, 44 bits
    typedef struct packed {
        logic [31:0] centerFreq;           // phase step per input sample
        logic        bypassCic;
        logic        bypassHb;             // stored only, no filter behind it
        logic        bypassFir;            // stored only
        logic        enableBasebandInputs;
        logic [7:0]  adcDecimation;        // 0 acts as 1
    } ddcCfgT;

endpackage

//--- verilog/ddcDspPkg.sv
/*
  Sample formats of the DSP chain.
  Input samples are signed 12 bit, complex samples carry re and im.
  The sum width covers 255 full-scale samples without overflow.
*/

package ddcDspPkg;

    localparam int sampleWidth = 12;
    localparam int sumWidth    = 20;

    typedef logic signed [sampleWidth-1:0] sampleT;

    typedef struct packed {
        sampleT re;
        sampleT im;
    } cplxT;

    typedef logic signed [sumWidth-1:0] sumT;

    // decimator output
    typedef struct packed {
        sumT re;
        sumT im;
    } cplxSumT;

endpackage

//--- verilog/ddcRegs.sv
/*
  Register block of the down-converter.
  Byte-lane writes on clk when cs and a wr strobe are high, combinational
  read-back that is zero with cs low. Drives the settings struct and a
  one-cycle pulse after the control or decimation register is written.
*/

`timescale 1ns/1ps

module ddcRegs (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [ddcRegPkg::addrWidth-1:0]  addr,
    input  logic [ddcRegPkg::dataWidth-1:0]  dataIn,
    output logic [ddcRegPkg::dataWidth-1:0]  dataOut,
    input  logic                             cs,
    input  logic                             wr0,
    input  logic                             wr1,
    input  logic                             wr2,
    input  logic                             wr3,
    output ddcRegPkg::ddcCfgT                cfg,
    output logic                             cfgChange
);
    import ddcRegPkg::*;

    logic [3:0] wrLane;
    logic       ctrlWrite;

    assign wrLane = {wr3, wr2, wr1, wr0};

    // only byte 0 exists in control and decimation
    assign ctrlWrite = cs && wr0 &&
                       (addr == ddcControlAddr || addr == ddcDecimationAddr);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg       <= '0;
            cfgChange <= 1'b0;
        end else begin
            cfgChange <= ctrlWrite;  // high the cycle the new cfg shows
            if (cs) begin
                case (addr)
                    ddcCenterFreqAddr: begin
                        for (int b = 0; b < 4; b++) begin
                            if (wrLane[b]) begin
                                cfg.centerFreq[8*b +: 8] <= dataIn[8*b +: 8];
                            end
                        end
                    end
                    ddcControlAddr: begin
                        if (wr0) begin
                            cfg.bypassCic            <= dataIn[0];
                            cfg.bypassHb             <= dataIn[1];
                            cfg.bypassFir            <= dataIn[2];
                            cfg.enableBasebandInputs <= dataIn[3];
                        end
                    end
                    ddcDecimationAddr: begin
                        if (wr0) begin
                            cfg.adcDecimation <= dataIn[7:0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                ddcCenterFreqAddr: dataOut = cfg.centerFreq;
                ddcControlAddr: begin
                    dataOut = {28'h0, cfg.enableBasebandInputs, cfg.bypassFir,
                               cfg.bypassHb, cfg.bypassCic};
                end
                ddcDecimationAddr: dataOut = {24'h0, cfg.adcDecimation};
                default: dataOut = '0;  // unused address
            endcase
        end
    end

endmodule

//--- verilog/ddcMixer.sv
/*
  Coarse frequency shift.
  A 32-bit phase accumulator steps by centerFreq on each input sample and
  its top two bits pick the NCO quadrant, so mixing is by +1, -1 or 0.
  In baseband mode the complex input passes unmixed. Output is one cycle
  after adcValid.
*/

`timescale 1ns/1ps

module ddcMixer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                adcValid,
    input  ddcDspPkg::sampleT   adcSample,
    input  ddcDspPkg::cplxT     bbSample,
    input  ddcRegPkg::ddcCfgT   cfg,
    output ddcDspPkg::cplxT     mixed,
    output logic                mixedValid
);
    import ddcDspPkg::*;

    logic [31:0] phase;
    logic [1:0]  quadrant;
    sampleT      negX;
    cplxT        mixNext;

    assign quadrant = phase[31:30];  // phase before this sample's step
    assign negX     = -adcSample;    // -2048 wraps onto itself

    always_comb begin
        if (cfg.enableBasebandInputs) begin
            mixNext = bbSample;
        end else begin
            case (quadrant)
                2'd0: begin
                    mixNext.re = adcSample;
                    mixNext.im = '0;
                end
                2'd1: begin
                    mixNext.re = '0;
                    mixNext.im = negX;
                end
                2'd2: begin
                    mixNext.re = negX;
                    mixNext.im = '0;
                end
                default: begin
                    mixNext.re = '0;
                    mixNext.im = adcSample;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase      <= '0;
            mixedValid <= 1'b0;
        end else begin
            mixedValid <= adcValid;
            if (adcValid) phase <= phase + cfg.centerFreq;  // advances in baseband too
        end
    end

    always_ff @(posedge clk) begin
        if (adcValid) mixed <= mixNext;
    end

endmodule

//--- verilog/ddcDecimator.sv
/*
  Integrate-and-dump decimator.
  Sums N mixed samples per block, N from adcDecimation with 0 taken as 1,
  and outputs the sums one cycle after the last sample of the block.
  With bypassCic each sample goes out sign-extended. cfgChange drops the
  partial block together with any sample arriving in that cycle.
*/

`timescale 1ns/1ps

module ddcDecimator (
    input  logic                clk,
    input  logic                rstN,
    input  logic                cfgChange,
    input  logic                mixedValid,
    input  ddcDspPkg::cplxT     mixed,
    input  ddcRegPkg::ddcCfgT   cfg,
    output ddcDspPkg::cplxSumT  outSample,
    output logic                outValid
);
    import ddcDspPkg::*;

    logic [7:0] blockLen;
    logic [7:0] count;     // samples already in the sums
    sumT        accRe;
    sumT        accIm;
    sumT        nextRe;
    sumT        nextIm;
    logic       blockDone;

    assign blockLen  = (cfg.adcDecimation == 8'd0) ? 8'd1 : cfg.adcDecimation;
    assign nextRe    = accRe + sumT'(mixed.re);
    assign nextIm    = accIm + sumT'(mixed.im);
    assign blockDone = (count >= blockLen - 8'd1);  // this sample closes the block

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count    <= '0;
            accRe    <= '0;
            accIm    <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= 1'b0;
            if (cfgChange) begin
                count <= '0;
                accRe <= '0;
                accIm <= '0;
            end else if (mixedValid) begin
                if (cfg.bypassCic || blockDone) begin
                    outValid <= 1'b1;
                end
                if (!cfg.bypassCic) begin
                    count <= blockDone ? 8'd0 : count + 8'd1;
                    accRe <= blockDone ? sumT'(0) : nextRe;
                    accIm <= blockDone ? sumT'(0) : nextIm;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mixedValid && !cfgChange) begin
            if (cfg.bypassCic) begin
                outSample.re <= sumT'(mixed.re);
                outSample.im <= sumT'(mixed.im);
            end else if (blockDone) begin
                outSample.re <= nextRe;
                outSample.im <= nextIm;
            end
        end
    end

endmodule

//--- verilog/ddcTop.sv
/*
  Top level of the down-converter.
  The register block feeds the mixer and the decimator. An input sample
  marked by adcValid leaves as outSample with outValid two cycles later,
  or two cycles after the last sample of a block when decimating.
*/

`timescale 1ns/1ps

module ddcTop (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [ddcRegPkg::addrWidth-1:0]  addr,
    input  logic [ddcRegPkg::dataWidth-1:0]  dataIn,
    output logic [ddcRegPkg::dataWidth-1:0]  dataOut,
    input  logic                             cs,
    input  logic                             wr0,
    input  logic                             wr1,
    input  logic                             wr2,
    input  logic                             wr3,
    input  logic                             adcValid,
    input  ddcDspPkg::sampleT                adcSample,
    input  ddcDspPkg::cplxT                  bbSample,
    output ddcDspPkg::cplxSumT               outSample,
    output logic                             outValid
);
    import ddcRegPkg::*;
    import ddcDspPkg::*;

    ddcCfgT cfg;
    logic   cfgChange;   // clears the decimator
    cplxT   mixed;
    logic   mixedValid;

    ddcRegs regs0 (
        .clk       (clk),
        .rstN      (rstN),
        .addr      (addr),
        .dataIn    (dataIn),
        .dataOut   (dataOut),
        .cs        (cs),
        .wr0       (wr0),
        .wr1       (wr1),
        .wr2       (wr2),
        .wr3       (wr3),
        .cfg       (cfg),
        .cfgChange (cfgChange)
    );

    ddcMixer mixer0 (
        .clk        (clk),
        .rstN       (rstN),
        .adcValid   (adcValid),
        .adcSample  (adcSample),
        .bbSample   (bbSample),
        .cfg        (cfg),
        .mixed      (mixed),
        .mixedValid (mixedValid)
    );

    ddcDecimator decim0 (
        .clk        (clk),
        .rstN       (rstN),
        .cfgChange  (cfgChange),
        .mixedValid (mixedValid),
        .mixed      (mixed),
        .cfg        (cfg),
        .outSample  (outSample),
        .outValid   (outValid)
    );

endmodule

//--- tests/ddcTb.sv
/*
  Testbench of the down-converter.
  Drives the register bus and the sample inputs on the falling edge and
  looks at the outputs there as well. A model of the registers, phase,
  quadrant mix and block sums predicts every read and every outValid.
  Compile with build.f.
*/

`timescale 1ns/1ps

module ddcTb;
    import ddcRegPkg::*;
    import ddcDspPkg::*;

    localparam int stimCycles = 1500;  // upper bound of all five tests
    localparam int cycleLimit = 2 * stimCycles;

    logic                 clk;
    logic                 rstN;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] dataIn;
    logic [dataWidth-1:0] dataOut;
    logic                 cs;
    logic                 wr0;
    logic                 wr1;
    logic                 wr2;
    logic                 wr3;
    logic                 adcValid;
    sampleT               adcSample;
    cplxT                 bbSample;
    cplxSumT              outSample;
    logic                 outValid;

    logic [31:0] lfsr;
    logic [31:0] shadow [0:3];  // entry 3 is an unused address
    logic [31:0] phase;         // model NCO phase
    sumT         accRe;
    sumT         accIm;
    int          count;
    cplxSumT     expQ [$];      // outputs still due
    int          dueQ [$];      // cycle in which each due output shows
    int          passCount;
    int          failCount;
    int          cycles = 0;

    ddcTop dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout, the run took more than %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] regMask(input logic [1:0] a);
        case (a)
            2'd0: return 32'hffff_ffff;
            2'd1: return 32'h0000_000f;  // four control bits
            2'd2: return 32'h0000_00ff;
            default: return 32'h0;
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [dataWidth-1:0] exp,
                             input logic [dataWidth-1:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkSum(input string name, input cplxSumT exp, input cplxSumT act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected (%0d, %0d), got (%0d, %0d)",
                     $time, name, exp.re, exp.im, act.re, act.im);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    // one clock with the outputs looked at on the falling edge
    task automatic tick();
        @(negedge clk);
        if (outValid) begin
            if (expQ.size() == 0) begin
                $display("unexpected outValid at %0t, no output was due", $time);
                failCount++;
            end else begin
                if (cycles != dueQ[0]) begin
                    $display("outValid at %0t came in cycle %0d but was due in cycle %0d",
                             $time, cycles, dueQ[0]);
                    failCount++;
                end
                dueQ.delete(0);
                checkSum("outSample", expQ.pop_front(), outSample);
            end
        end
    endtask

    task automatic busWrite(input logic [1:0] a, input logic [31:0] d, input logic [3:0] lanes);
        logic [31:0] m;
        addr = {{(addrWidth-2){1'b0}}, a};
        dataIn = d;
        cs = 1'b1;
        {wr3, wr2, wr1, wr0} = lanes;
        tick();
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        m = regMask(a);
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) shadow[a][8*b +: 8] = d[8*b +: 8] & m[8*b +: 8];
        end
        if ((a == 2'd1 || a == 2'd2) && lanes[0]) begin
            count = 0;  // partial block dropped
            accRe = '0;
            accIm = '0;
        end
    endtask

    task automatic readCheck(input logic [1:0] a, input logic sel);
        addr = {{(addrWidth-2){1'b0}}, a};
        cs = sel;
        #2;
        checkWord("dataOut", sel ? shadow[a] : 32'h0, dataOut);
        tick();
        cs = 1'b0;
    endtask

    task automatic sendSample(input logic gaps);
        logic [31:0] r;
        sampleT      x;
        cplxT        bb;
        cplxT        mix;
        cplxSumT     e;
        int          blockLen;
        r = randBits(12);
        x = r[11:0];
        r = randBits(24);
        bb = r[23:0];
        blockLen = (shadow[2][7:0] == 8'd0) ? 1 : int'(shadow[2][7:0]);
        mix = '0;
        case (phase[31:30])  // phase before this sample's step
            2'd0: mix.re = x;
            2'd1: mix.im = -x;  // 12-bit negate keeps -2048
            2'd2: mix.re = -x;
            default: mix.im = x;
        endcase
        if (shadow[1][3]) mix = bb;
        phase = phase + shadow[0];
        if (shadow[1][0]) begin
            e.re = sumT'(mix.re);
            e.im = sumT'(mix.im);
            expQ.push_back(e);
            dueQ.push_back(cycles + 2);
        end else begin
            accRe = accRe + sumT'(mix.re);
            accIm = accIm + sumT'(mix.im);
            count++;
            if (count >= blockLen) begin
                e.re = accRe;
                e.im = accIm;
                expQ.push_back(e);
                dueQ.push_back(cycles + 2);
                count = 0;
                accRe = '0;
                accIm = '0;
            end
        end
        adcValid = 1'b1;
        adcSample = x;
        bbSample = bb;
        tick();
        adcValid = 1'b0;
        if (gaps) repeat (randBits(2)) tick();
    endtask

    // waits for the due outputs and then a few cycles more for extra ones
    task automatic drainOutputs();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < 8) begin
            tick();
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("missing outValid at %0t, %0d outputs never came", $time, expQ.size());
            failCount += expQ.size();
            expQ.delete();
            dueQ.delete();
        end
        repeat (3) tick();
    endtask

    task automatic reportTest(input string name, input int startFails);
        $display("%s finished with %0d errors", name, failCount - startFails);
    endtask

    initial begin
        int          startFails;
        int          n;
        logic [31:0] r;
        logic [1:0]  ra;
        logic [3:0]  rl;
        clk = 1'b0;
        rstN = 1'b0;
        addr = '0;
        dataIn = '0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        adcValid = 1'b0;
        adcSample = '0;
        bbSample = '0;
        lfsr = 32'hfd9d;
        phase = '0;
        accRe = '0;
        accIm = '0;
        count = 0;
        passCount = 0;
        failCount = 0;
        for (int a = 0; a < 4; a++) shadow[a] = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        startFails = failCount;
        for (int a = 0; a < 4; a++) readCheck(2'(a), 1'b1);
        for (int i = 0; i < 16; i++) begin
            r = randBits(2);
            ra = r[1:0];
            r = randBits(4);
            rl = r[3:0];
            busWrite(ra, randBits(32), rl);
            readCheck(ra, 1'b1);
        end
        busWrite(2'd1, 32'hffff_fff5, 4'b1111);  // only bits 0 and 2 stick
        readCheck(2'd1, 1'b1);
        readCheck(2'd1, 1'b0);
        reportTest("reset and read-back", startFails);

        startFails = failCount;
        busWrite(2'd0, randBits(32), 4'b1111);
        busWrite(2'd1, 32'h1, 4'b0001);
        for (int i = 0; i < 40; i++) sendSample(1'b0);
        drainOutputs();
        reportTest("bypass mixing", startFails);

        startFails = failCount;
        busWrite(2'd1, 32'h0, 4'b0001);
        for (int round = 0; round < 5; round++) begin
            r = randBits(4);
            n = (round == 4) ? 0 : int'(r[3:0]) + 1;
            busWrite(2'd2, 32'(n), 4'b0001);
            for (int i = 0; i < ((n == 0) ? 1 : n) * 3; i++) sendSample(1'b1);
            drainOutputs();
        end
        reportTest("decimation", startFails);

        startFails = failCount;
        busWrite(2'd0, randBits(32), 4'b1111);
        busWrite(2'd1, 32'h8, 4'b0001);
        r = randBits(3);
        busWrite(2'd2, 32'(int'(r[2:0]) + 2), 4'b0001);
        for (int i = 0; i < 27; i++) sendSample(1'b1);
        drainOutputs();
        reportTest("baseband input", startFails);

        startFails = failCount;
        busWrite(2'd1, 32'h0, 4'b0001);
        busWrite(2'd2, 32'h8, 4'b0001);
        for (int i = 0; i < 5; i++) sendSample(1'b0);
        busWrite(2'd1, 32'h0, 4'b0001);  // same value still restarts the block
        for (int i = 0; i < 16; i++) sendSample(1'b0);
        drainOutputs();
        reportTest("configuration change mid-block", startFails);

        $display("checks passed %0d, checks failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/ddcRegPkg.sv
verilog/ddcDspPkg.sv
verilog/ddcRegs.sv
verilog/ddcMixer.sv
verilog/ddcDecimator.sv
verilog/ddcTop.sv
tests/ddcTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the down-converter with Verilator and run its testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module ddcTb &&
./obj_dir/VddcTb | tee /dev/stderr | grep "Test completed successfully" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
